/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= xbar_tb
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log

SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := verilog/xbar_config.svh
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* sources.f */
+incdir+verilog
verilog/xbar_pkg.sv
verilog/xbar_bus_if.sv
verilog/addr_decode.sv
verilog/chan_slice.sv
verilog/err_target.sv
verilog/xbar_ctrl.sv
verilog/xbar_top.sv
tests/xbar_tb.sv

/* tests/xbar_tb.sv */
`timescale 1ns/1ps
`include "xbar_config.svh"

module xbar_tb;

  localparam int NI       = `XBAR_NUM_INIT;
  localparam int NT       = `XBAR_NUM_TGT;
  localparam int NUM_XACT = 28; // 4 arbitration, 4 mapped, 4 unmapped, 16 random

  logic                                  clk_i;
  logic                                  rst_i;
  logic [NI-1:0]                         init_req_valid_i, init_req_ready_o;
  xbar_pkg::req_t [NI-1:0]               init_req_i;
  logic [NI-1:0]                         init_rsp_valid_o, init_rsp_ready_i;
  xbar_pkg::rsp_t [NI-1:0]               init_rsp_o;
  logic [NT-1:0]                         tgt_req_valid_o, tgt_req_ready_i;
  xbar_pkg::req_t [NT-1:0]               tgt_req_o;
  logic [NT-1:0]                         tgt_rsp_valid_i, tgt_rsp_ready_o;
  xbar_pkg::rsp_t [NT-1:0]               tgt_rsp_i;
  xbar_pkg::rule_t [NT-1:0]              addr_map_i;
  logic [NI-1:0]                         en_default_i;
  xbar_pkg::tgt_idx_t [NI-1:0]           default_tgt_i;

  integer                  seed = 32'h95ad_b027;
  logic [`XBAR_DATA_W-1:0] mem [NT][256];
  logic [NT-1:0]           rsp_pend;
  xbar_pkg::rsp_t [NT-1:0] rsp_next; // Response data, driven after the edge
  logic [15:0]             t0_addrs [$]; // Arrival order at target 0
  bit                      bp_on;
  int                      req_cnt, rsp_cnt;
  int                      pend_cnt [NI];
  xbar_pkg::rsp_t          rsp_a, rsp_b;

  xbar_top dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_error(input string msg);
    $display("test failed");
    $display("[ERROR] %0t: %s", $time, msg);
    $fatal(1, "stopped at first error");
  endtask

  // Port index from the fixed test map, 2 means the error responder
  function automatic int map_port(input logic [15:0] addr, input logic en_def, input int def);
    if (addr <= 16'h0FFF) return 0;
    if (addr <= 16'h1FFF) return 1;
    if (en_def) return def;
    return 2;
  endfunction

  function automatic bit routed_ok(input logic [15:0] addr, input int t);
    bit ok;
    ok = 1'b0;
    for (int i = 0; i < NI; i++) begin
      if (map_port(addr, en_default_i[i], int'(default_tgt_i[i])) == t) ok = 1'b1;
    end
    return ok;
  endfunction

  // One transaction on initiator i, called 1 ns after a rising edge
  task automatic do_xact(input int i, input logic wr, input logic [15:0] addr,
                         input logic [31:0] wdata, input bit chk_lat, input int lat_tgt,
                         output xbar_pkg::rsp_t rsp);
    init_req_valid_i[i]  = 1'b1;
    init_req_i[i].write  = wr;
    init_req_i[i].addr   = addr;
    init_req_i[i].wdata  = wdata;
    do @(posedge clk_i); while (!init_req_ready_o[i]);
    #1 init_req_valid_i[i] = 1'b0;
    if (chk_lat) begin
      @(posedge clk_i);
      assert (!tgt_req_valid_o[lat_tgt])
        else report_error("request reached the target one cycle early");
      @(posedge clk_i);
      assert (tgt_req_valid_o[lat_tgt] && tgt_req_o[lat_tgt].addr == addr)
        else report_error("request missing at its target two cycles after acceptance");
    end
    do @(posedge clk_i); while (!(init_rsp_valid_o[i] && init_rsp_ready_i[i]));
    rsp = init_rsp_o[i];
    #1;
  endtask

  task automatic check_rsp(input xbar_pkg::rsp_t rsp, input bit chk_data,
                           input logic [31:0] exp_data, input logic exp_err, input string what);
    assert ((!chk_data || rsp.rdata == exp_data) && rsp.err == exp_err)
      else report_error($sformatf("%s: got rdata 0x%h err %0b, expected 0x%h err %0b",
                                  what, rsp.rdata, rsp.err, exp_data, exp_err));
  endtask

  // Disjoint address sets per initiator keep expected data local
  task automatic random_traffic(input int i);
    int             tgt;
    logic [15:0]    addr;
    logic [31:0]    wdata;
    xbar_pkg::rsp_t rsp;
    for (int k = 0; k < 4; k++) begin
      tgt   = $random(seed) & 1;
      addr  = 16'(tgt * 'h1000 + i * 'h80 + k * 4);
      wdata = $random(seed);
      do_xact(i, 1'b1, addr, wdata, 1'b0, 0, rsp);
      check_rsp(rsp, 1'b0, '0, 1'b0, "random write");
      do_xact(i, 1'b0, addr, '0, 1'b0, 0, rsp);
      check_rsp(rsp, 1'b1, wdata, 1'b0, "random read");
    end
  endtask

  // Behavioral target memories, answering one cycle after a request
  initial begin : target_models
    tgt_req_ready_i  = '1;
    tgt_rsp_valid_i  = '0;
    tgt_rsp_i        = '0;
    init_rsp_ready_i = '1;
    rsp_pend         = '0;
    rsp_next         = '0;
    for (int t = 0; t < NT; t++) begin
      for (int a = 0; a < 256; a++) begin
        mem[t][a] = 32'hA5A5_0000 ^ 32'((t << 12) | a);
      end
    end
    forever begin
      @(posedge clk_i);
      for (int t = 0; t < NT; t++) begin
        if (rst_i) begin
          rsp_pend[t] = 1'b0;
        end else begin
          if (tgt_rsp_valid_i[t] && tgt_rsp_ready_o[t]) rsp_pend[t] = 1'b0;
          if (tgt_req_valid_o[t]) begin
            assert (routed_ok(tgt_req_o[t].addr, t))
              else report_error($sformatf("address 0x%h shown at target %0d",
                                          tgt_req_o[t].addr, t));
          end
          if (tgt_req_valid_o[t] && tgt_req_ready_i[t]) begin
            assert (!rsp_pend[t]) else report_error("second request while a response is pending");
            if (t == 0) t0_addrs.push_back(tgt_req_o[t].addr);
            rsp_next[t].err   = 1'b0;
            rsp_next[t].rdata = tgt_req_o[t].write ? '0 : mem[t][tgt_req_o[t].addr[7:0]];
            if (tgt_req_o[t].write) mem[t][tgt_req_o[t].addr[7:0]] = tgt_req_o[t].wdata;
            rsp_pend[t] = 1'b1;
          end
        end
      end
      #1;
      tgt_rsp_i        = rsp_next;
      tgt_rsp_valid_i  = rsp_pend;
      tgt_req_ready_i  = bp_on ? NT'($random(seed)) : '1;
      init_rsp_ready_i = bp_on ? NI'($random(seed)) : '1;
    end
  end

  // Handshakes seen at the initiator ports
  initial begin : xact_monitor
    forever begin
      @(posedge clk_i);
      if (!rst_i) begin
        for (int i = 0; i < NI; i++) begin
          if (init_req_valid_i[i] && init_req_ready_o[i]) begin
            req_cnt++;
            pend_cnt[i]++;
          end
          if (init_rsp_valid_o[i] && init_rsp_ready_i[i]) begin
            assert (pend_cnt[i] > 0)
              else report_error($sformatf("response at initiator %0d with no open request", i));
            rsp_cnt++;
            pend_cnt[i]--;
          end
        end
      end
    end
  end

  // Held valid keeps its payload under back-pressure
  for (genvar t = 0; t < NT; t++) begin : gen_tgt_chk
    tgt_req_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      tgt_req_valid_o[t] && !tgt_req_ready_i[t] |=> tgt_req_valid_o[t] && $stable(tgt_req_o[t]))
      else report_error("target request dropped or changed while stalled");
  end

  for (genvar i = 0; i < NI; i++) begin : gen_init_chk
    init_rsp_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=>
        init_rsp_valid_o[i] && $stable(init_rsp_o[i]))
      else report_error("initiator response dropped or changed while stalled");
  end

  initial begin : watchdog
    repeat (200 * NUM_XACT) @(posedge clk_i);
    $display("test failed");
    $display("Timeout: the run did not finish within %0d cycles", 200 * NUM_XACT);
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    rst_i            = 1'b1;
    init_req_valid_i = '0;
    init_req_i       = '0;
    en_default_i     = '0;
    default_tgt_i    = '0;
    bp_on            = 1'b0;
    addr_map_i[0]    = '{idx: 0, start_addr: 16'h0000, end_addr: 16'h0FFF};
    addr_map_i[1]    = '{idx: 1, start_addr: 16'h1000, end_addr: 16'h1FFF};
    repeat (8) @(posedge clk_i);
    #1 rst_i = 1'b0;
    repeat (4) begin
      @(posedge clk_i);
      assert (tgt_req_valid_o == '0 && init_rsp_valid_o == '0)
        else report_error("valid output high after reset with idle inputs");
    end
    #1;
    // Same target in the same cycle, initiator 0 wins first
    fork
      do_xact(0, 1'b1, 16'h0010, 32'h1111_0010, 1'b0, 0, rsp_a);
      do_xact(1, 1'b1, 16'h0020, 32'h2222_0020, 1'b0, 0, rsp_b);
    join
    assert (t0_addrs.size() == 2 && t0_addrs[0] == 16'h0010 && t0_addrs[1] == 16'h0020)
      else report_error("round-robin order wrong on the first writes");
    check_rsp(rsp_a, 1'b0, '0, 1'b0, "initiator 0 write");
    check_rsp(rsp_b, 1'b0, '0, 1'b0, "initiator 1 write");
    fork
      do_xact(0, 1'b0, 16'h0010, '0, 1'b0, 0, rsp_a);
      do_xact(1, 1'b0, 16'h0020, '0, 1'b0, 0, rsp_b);
    join
    assert (t0_addrs.size() == 4 && t0_addrs[2] == 16'h0010 && t0_addrs[3] == 16'h0020)
      else report_error("round-robin order wrong on the reads");
    check_rsp(rsp_a, 1'b1, 32'h1111_0010, 1'b0, "initiator 0 read");
    check_rsp(rsp_b, 1'b1, 32'h2222_0020, 1'b0, "initiator 1 read");
    // Mapped write then read, with the 2-cycle request latency
    do_xact(0, 1'b1, 16'h0124, 32'hCAFE_0124, 1'b1, 0, rsp_a);
    check_rsp(rsp_a, 1'b0, '0, 1'b0, "target 0 write");
    do_xact(0, 1'b0, 16'h0124, '0, 1'b1, 0, rsp_a);
    check_rsp(rsp_a, 1'b1, 32'hCAFE_0124, 1'b0, "target 0 read");
    do_xact(1, 1'b1, 16'h1ABC, 32'hBEEF_1ABC, 1'b1, 1, rsp_b);
    check_rsp(rsp_b, 1'b0, '0, 1'b0, "target 1 write");
    do_xact(1, 1'b0, 16'h1ABC, '0, 1'b1, 1, rsp_b);
    check_rsp(rsp_b, 1'b1, 32'hBEEF_1ABC, 1'b0, "target 1 read");
    // Unmapped, no default, so the error responder answers
    do_xact(0, 1'b0, 16'h8000, '0, 1'b0, 0, rsp_a);
    check_rsp(rsp_a, 1'b1, '0, 1'b1, "unmapped read");
    do_xact(0, 1'b1, 16'h9000, 32'h0BAD_9000, 1'b0, 0, rsp_a);
    check_rsp(rsp_a, 1'b1, '0, 1'b1, "unmapped write");
    en_default_i[0]  = 1'b1;
    default_tgt_i[0] = 1;
    do_xact(0, 1'b1, 16'h8000, 32'h5A5A_8000, 1'b1, 1, rsp_a);
    check_rsp(rsp_a, 1'b0, '0, 1'b0, "default write");
    do_xact(0, 1'b0, 16'h8000, '0, 1'b1, 1, rsp_a);
    check_rsp(rsp_a, 1'b1, 32'h5A5A_8000, 1'b0, "default read");
    en_default_i = '0;
    // Random back-pressure on both sides
    bp_on = 1'b1;
    fork
      random_traffic(0);
      random_traffic(1);
    join
    bp_on = 1'b0;
    if (req_cnt == NUM_XACT && rsp_cnt == NUM_XACT) begin
      $display("test passed");
      $finish;
    end else begin
      report_error($sformatf("%0d requests and %0d responses, expected %0d each",
                             req_cnt, rsp_cnt, NUM_XACT));
    end
  end

endmodule

/* verilog/addr_decode.sv */
`timescale 1ns/1ps
`include "xbar_config.svh"

module addr_decode (
  input  logic [`XBAR_ADDR_W-1:0]                   addr_i,
  input  xbar_pkg::rule_t [`XBAR_NUM_TGT-1:0]       addr_map_i,
  input  logic                                      en_default_i,
  input  xbar_pkg::tgt_idx_t                        default_tgt_i,
  output xbar_pkg::tgt_idx_t                        idx_o
);

  logic match;

  always_comb begin
    match = 1'b0;
    idx_o = xbar_pkg::tgt_idx_t'(`XBAR_NUM_TGT); // Error target unless a rule hits
    // Lowest matching rule takes precedence
    for (int r = 0; r < `XBAR_NUM_TGT; r++) begin
      if (!match &&
          addr_i >= addr_map_i[r].start_addr &&
          addr_i <= addr_map_i[r].end_addr) begin
        match = 1'b1;
        idx_o = addr_map_i[r].idx;
      end
    end
    if (!match && en_default_i) begin
      idx_o = default_tgt_i; // Fall back to the initiator's default
    end
  end

endmodule

/* verilog/chan_slice.sv */
`timescale 1ns/1ps

module chan_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;

  // Free slot, or the held item leaves this cycle
  assign in_ready_o  = !full_q || out_ready_i;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0; // Drained without a refill
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

endmodule

/* verilog/err_target.sv */
`timescale 1ns/1ps

module err_target (
  input  logic              clk_i,
  input  logic              rst_i,
  xbar_bus_if.target        bus
);

  logic full_q;

  // Accept only while no error response is pending
  assign bus.req_ready = !full_q;
  assign bus.rsp_valid = full_q;
  assign bus.rsp       = '{rdata: '0, err: 1'b1};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (bus.req_valid && !full_q) begin
      full_q <= 1'b1; // Response shows up on the next cycle
    end else if (bus.rsp_ready) begin
      full_q <= 1'b0;
    end
  end

endmodule

/* verilog/xbar_bus_if.sv */
`timescale 1ns/1ps

interface xbar_bus_if;

  // Request channel
  logic           req_valid;
  logic           req_ready;
  xbar_pkg::req_t req;

  // Response channel
  logic           rsp_valid;
  logic           rsp_ready;
  xbar_pkg::rsp_t rsp;

  modport initiator (
    output req_valid,
    input  req_ready,
    output req,
    input  rsp_valid,
    output rsp_ready,
    input  rsp
  );

  modport target (
    input  req_valid,
    output req_ready,
    input  req,
    output rsp_valid,
    input  rsp_ready,
    output rsp
  );

endinterface

/* verilog/xbar_config.svh */
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

// Port counts of the crossbar
`define XBAR_NUM_INIT 2
`define XBAR_NUM_TGT  2

// Field widths of a request
`define XBAR_ADDR_W 16
`define XBAR_DATA_W 32

`endif

/* verilog/xbar_ctrl.sv */
`timescale 1ns/1ps
`include "xbar_config.svh"

module xbar_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  xbar_pkg::rule_t [`XBAR_NUM_TGT-1:0]   addr_map_i,
  input  logic [`XBAR_NUM_INIT-1:0]             en_default_i,
  input  xbar_pkg::tgt_idx_t [`XBAR_NUM_INIT-1:0] default_tgt_i,
  xbar_bus_if.target                            init_bus [`XBAR_NUM_INIT],
  xbar_bus_if.initiator                         tgt_bus [`XBAR_NUM_TGT + 1]
);

  localparam int NUM_INIT  = `XBAR_NUM_INIT;
  localparam int NUM_PORTS = `XBAR_NUM_TGT + 1; // Last port is the error target

  // Initiator side, flattened
  logic [NUM_INIT-1:0]                     in_req_valid, in_req_ready;
  logic [NUM_INIT-1:0]                     in_rsp_valid, in_rsp_ready;
  xbar_pkg::req_t [NUM_INIT-1:0]           in_req;
  xbar_pkg::rsp_t [NUM_INIT-1:0]           in_rsp;
  xbar_pkg::tgt_idx_t [NUM_INIT-1:0]       dec_idx;
  logic [NUM_INIT-1:0]                     cand_req;

  // Target side, flattened
  logic [NUM_PORTS-1:0]                    out_req_valid, out_req_ready;
  logic [NUM_PORTS-1:0]                    out_rsp_valid, out_rsp_ready;
  xbar_pkg::req_t [NUM_PORTS-1:0]          out_req;
  xbar_pkg::rsp_t [NUM_PORTS-1:0]          out_rsp;

  logic [NUM_PORTS-1:0]                    grant_valid, req_hs, rsp_hs;
  xbar_pkg::init_idx_t [NUM_PORTS-1:0]     grant_idx;

  // Ownership and arbitration state
  logic [NUM_INIT-1:0]                     init_busy_q;
  logic [NUM_PORTS-1:0]                    tgt_busy_q;
  xbar_pkg::init_idx_t [NUM_PORTS-1:0]     owner_q;
  xbar_pkg::init_idx_t [NUM_PORTS-1:0]     rr_ptr_q;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    assign in_req_valid[i]       = init_bus[i].req_valid;
    assign in_req[i]             = init_bus[i].req;
    assign in_rsp_ready[i]       = init_bus[i].rsp_ready;
    assign init_bus[i].req_ready = in_req_ready[i];
    assign init_bus[i].rsp_valid = in_rsp_valid[i];
    assign init_bus[i].rsp       = in_rsp[i];
    assign cand_req[i]           = in_req_valid[i] && !init_busy_q[i]; // One outstanding each

    addr_decode u_dec (
      .addr_i        (init_bus[i].req.addr),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_i[i]),
      .default_tgt_i (default_tgt_i[i]),
      .idx_o         (dec_idx[i])
    );
  end

  for (genvar t = 0; t < NUM_PORTS; t++) begin : gen_tgt
    assign tgt_bus[t].req_valid = out_req_valid[t];
    assign tgt_bus[t].req       = out_req[t];
    assign tgt_bus[t].rsp_ready = out_rsp_ready[t];
    assign out_req_ready[t]     = tgt_bus[t].req_ready;
    assign out_rsp_valid[t]     = tgt_bus[t].rsp_valid;
    assign out_rsp[t]           = tgt_bus[t].rsp;
  end

  // Round-robin pick per idle target, starting at its pointer
  always_comb begin
    int cand;
    for (int t = 0; t < NUM_PORTS; t++) begin
      grant_valid[t] = 1'b0;
      grant_idx[t]   = rr_ptr_q[t];
      for (int k = 0; k < NUM_INIT; k++) begin
        cand = int'(rr_ptr_q[t]) + k;
        if (cand >= NUM_INIT) begin
          cand = cand - NUM_INIT;
        end
        if (!grant_valid[t] && !tgt_busy_q[t] && cand_req[cand] &&
            dec_idx[cand] == xbar_pkg::tgt_idx_t'(t)) begin
          grant_valid[t] = 1'b1;
          grant_idx[t]   = xbar_pkg::init_idx_t'(cand);
        end
      end
    end
  end

  // Request routing, ready goes back to the granted initiator only
  always_comb begin
    in_req_ready = '0;
    for (int t = 0; t < NUM_PORTS; t++) begin
      out_req_valid[t] = grant_valid[t];
      out_req[t]       = in_req[grant_idx[t]];
      req_hs[t]        = grant_valid[t] && out_req_ready[t];
      if (req_hs[t]) begin
        in_req_ready[grant_idx[t]] = 1'b1;
      end
    end
  end

  // Responses follow the recorded owner
  always_comb begin
    in_rsp_valid = '0;
    in_rsp       = '0;
    for (int t = 0; t < NUM_PORTS; t++) begin
      out_rsp_ready[t] = tgt_busy_q[t] && in_rsp_ready[owner_q[t]];
      rsp_hs[t]        = out_rsp_valid[t] && out_rsp_ready[t];
      if (tgt_busy_q[t] && out_rsp_valid[t]) begin
        in_rsp_valid[owner_q[t]] = 1'b1;
        in_rsp[owner_q[t]]       = out_rsp[t];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      init_busy_q <= '0;
      tgt_busy_q  <= '0;
      owner_q     <= '0;
      rr_ptr_q    <= '0; // Initiator 0 first
    end else begin
      for (int t = 0; t < NUM_PORTS; t++) begin
        if (req_hs[t]) begin
          tgt_busy_q[t]               <= 1'b1;
          owner_q[t]                  <= grant_idx[t];
          init_busy_q[grant_idx[t]]   <= 1'b1;
          // Granted initiator drops to lowest priority
          if (grant_idx[t] == xbar_pkg::init_idx_t'(NUM_INIT - 1)) begin
            rr_ptr_q[t] <= '0;
          end else begin
            rr_ptr_q[t] <= grant_idx[t] + 1'b1;
          end
        end else if (rsp_hs[t]) begin
          tgt_busy_q[t]             <= 1'b0;
          init_busy_q[owner_q[t]]   <= 1'b0;
        end
      end
    end
  end

endmodule

/* verilog/xbar_pkg.sv */
`include "xbar_config.svh"

package xbar_pkg;

  // One extra index value selects the internal error target
  typedef logic [$clog2(`XBAR_NUM_TGT + 1)-1:0] tgt_idx_t;

  // Kept at one bit or wider so a single initiator still has a valid index
  typedef logic [((`XBAR_NUM_INIT > 1) ? $clog2(`XBAR_NUM_INIT) : 1)-1:0] init_idx_t;

  // Single-beat request
  typedef struct packed {
    logic                    write;
    logic [`XBAR_ADDR_W-1:0] addr;
    logic [`XBAR_DATA_W-1:0] wdata;
  } req_t;

  // Response to any request
  typedef struct packed {
    logic [`XBAR_DATA_W-1:0] rdata;
    logic                    err;
  } rsp_t;

  // Address map entry, last address is inclusive
  typedef struct packed {
    tgt_idx_t                idx;
    logic [`XBAR_ADDR_W-1:0] start_addr;
    logic [`XBAR_ADDR_W-1:0] end_addr;
  } rule_t;

endpackage

/* verilog/xbar_top.sv */
`timescale 1ns/1ps
`include "xbar_config.svh"

module xbar_top (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // Initiator ports
  input  logic [`XBAR_NUM_INIT-1:0]                 init_req_valid_i,
  output logic [`XBAR_NUM_INIT-1:0]                 init_req_ready_o,
  input  xbar_pkg::req_t [`XBAR_NUM_INIT-1:0]       init_req_i,
  output logic [`XBAR_NUM_INIT-1:0]                 init_rsp_valid_o,
  input  logic [`XBAR_NUM_INIT-1:0]                 init_rsp_ready_i,
  output xbar_pkg::rsp_t [`XBAR_NUM_INIT-1:0]       init_rsp_o,
  // Target ports
  output logic [`XBAR_NUM_TGT-1:0]                  tgt_req_valid_o,
  input  logic [`XBAR_NUM_TGT-1:0]                  tgt_req_ready_i,
  output xbar_pkg::req_t [`XBAR_NUM_TGT-1:0]        tgt_req_o,
  input  logic [`XBAR_NUM_TGT-1:0]                  tgt_rsp_valid_i,
  output logic [`XBAR_NUM_TGT-1:0]                  tgt_rsp_ready_o,
  input  xbar_pkg::rsp_t [`XBAR_NUM_TGT-1:0]        tgt_rsp_i,
  // Address map and default routing
  input  xbar_pkg::rule_t [`XBAR_NUM_TGT-1:0]       addr_map_i,
  input  logic [`XBAR_NUM_INIT-1:0]                 en_default_i,
  input  xbar_pkg::tgt_idx_t [`XBAR_NUM_INIT-1:0]   default_tgt_i
);

  xbar_bus_if init_bus [`XBAR_NUM_INIT] ();
  xbar_bus_if tgt_bus [`XBAR_NUM_TGT + 1] (); // Extra entry feeds the error target

  for (genvar i = 0; i < `XBAR_NUM_INIT; i++) begin : gen_init_port
    chan_slice #(.payload_t(xbar_pkg::req_t)) u_req_slice (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (init_req_valid_i[i]),
      .in_ready_o  (init_req_ready_o[i]),
      .in_data_i   (init_req_i[i]),
      .out_valid_o (init_bus[i].req_valid),
      .out_ready_i (init_bus[i].req_ready),
      .out_data_o  (init_bus[i].req)
    );

    chan_slice #(.payload_t(xbar_pkg::rsp_t)) u_rsp_slice (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (init_bus[i].rsp_valid),
      .in_ready_o  (init_bus[i].rsp_ready),
      .in_data_i   (init_bus[i].rsp),
      .out_valid_o (init_rsp_valid_o[i]),
      .out_ready_i (init_rsp_ready_i[i]),
      .out_data_o  (init_rsp_o[i])
    );
  end

  for (genvar t = 0; t < `XBAR_NUM_TGT; t++) begin : gen_tgt_port
    chan_slice #(.payload_t(xbar_pkg::req_t)) u_req_slice (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (tgt_bus[t].req_valid),
      .in_ready_o  (tgt_bus[t].req_ready),
      .in_data_i   (tgt_bus[t].req),
      .out_valid_o (tgt_req_valid_o[t]),
      .out_ready_i (tgt_req_ready_i[t]),
      .out_data_o  (tgt_req_o[t])
    );

    chan_slice #(.payload_t(xbar_pkg::rsp_t)) u_rsp_slice (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (tgt_rsp_valid_i[t]),
      .in_ready_o  (tgt_rsp_ready_o[t]),
      .in_data_i   (tgt_rsp_i[t]),
      .out_valid_o (tgt_bus[t].rsp_valid),
      .out_ready_i (tgt_bus[t].rsp_ready),
      .out_data_o  (tgt_bus[t].rsp)
    );
  end

  xbar_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .addr_map_i    (addr_map_i),
    .en_default_i  (en_default_i),
    .default_tgt_i (default_tgt_i),
    .init_bus      (init_bus),
    .tgt_bus       (tgt_bus)
  );

  // Catches decode misses
  err_target u_err (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (tgt_bus[`XBAR_NUM_TGT])
  );

endmodule
